// ==== rv_core.f ====
+incdir+testbench
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_fetch.sv
hdl/rv_core.sv
testbench/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - hdl/rv_isa_pkg.sv
      - hdl/rv_core_pkg.sv
      - hdl/rv_decoder.sv
      - hdl/rv_regfile.sv
      - hdl/rv_execute.sv
      - hdl/rv_fetch.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_rv_core.sv

// ==== testbench/rv_program.svh ====
`ifndef RV_PROGRAM_SVH
`define RV_PROGRAM_SVH

// opcodes used by the test program
localparam logic [6:0] OPC_LOAD  = 7'b0000011;
localparam logic [6:0] OPC_IMM   = 7'b0010011;
localparam logic [6:0] OPC_AUIPC = 7'b0010111;
localparam logic [6:0] OPC_LUI   = 7'b0110111;
localparam logic [6:0] OPC_JALR  = 7'b1100111;

// value parked in skipped stores
localparam word_t POISON = 32'hdead_0000;

// load sources
localparam word_t DATA0 = 32'h0000_0400;
localparam word_t DATA1 = 32'h0000_0404;

function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                input logic [4:0] rs1, input logic [2:0] f3,
                                input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t enc_i(input word_t imm, input logic [4:0] rs1,
                                input logic [2:0] f3, input logic [4:0] rd,
                                input logic [6:0] op);
  return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic word_t enc_s(input word_t imm, input logic [4:0] rs2,
                                input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic word_t enc_b(input word_t imm, input logic [4:0] rs2,
                                input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic word_t enc_u(input word_t imm20, input logic [4:0] rd,
                                input logic [6:0] op);
  return {imm20[19:0], rd, op};
endfunction

function automatic word_t enc_j(input word_t imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// byte address of the next instruction slot
function automatic word_t cur_addr();
  return word_t'(prog_len * 4);
endfunction

task automatic emit_to(input word_t insn, input word_t next_pc);
  mem[prog_len]         = insn;
  next_pc_tbl[prog_len] = next_pc;
  prog_len++;
endtask

task automatic emit(input word_t insn);
  emit_to(insn, cur_addr() + 4);
endtask

// sw rs2 to an absolute address, value expected on the store port
task automatic emit_sw(input logic [4:0] rs2, input word_t addr, input word_t value);
  st_addr[num_stores] = addr;
  st_data[num_stores] = value;
  num_stores++;
  emit(enc_s(addr, rs2, 5'd0));
endtask

// store that a taken branch or jump has to skip
task automatic emit_poison();
  emit(enc_s(32'h5f0, 5'd22, 5'd0));
endtask

task automatic load_program(input word_t rand0, input word_t rand1);
  word_t link;
  prog_len   = 0;
  num_stores = 0;
  mem[DATA0[ADDR_MSB:2]] = rand0;
  mem[DATA1[ADDR_MSB:2]] = rand1;
  // x1 = 100, x2 = -7
  emit(enc_i(100, 0, 3'b000, 1, OPC_IMM));
  emit(enc_i(-7, 0, 3'b000, 2, OPC_IMM));
  emit(enc_r(7'h00, 2, 1, 3'b000, 3));
  emit_sw(3, 32'h500, 32'd93);
  emit(enc_r(7'h20, 2, 1, 3'b000, 4));
  emit_sw(4, 32'h504, 32'd107);
  emit(enc_i(4, 1, 3'b001, 5, OPC_IMM));
  emit_sw(5, 32'h508, 32'h640);
  emit(enc_i(28, 2, 3'b101, 6, OPC_IMM));
  emit_sw(6, 32'h50c, 32'h0000_000f);
  // srai of a negative value
  emit(enc_i(32'h401, 2, 3'b101, 7, OPC_IMM));
  emit_sw(7, 32'h510, 32'hffff_fffc);
  // register shifts by x8 = 3
  emit(enc_i(3, 0, 3'b000, 8, OPC_IMM));
  emit(enc_r(7'h00, 8, 1, 3'b001, 9));
  emit_sw(9, 32'h514, 32'h320);
  emit(enc_r(7'h20, 8, 2, 3'b101, 10));
  emit_sw(10, 32'h518, 32'hffff_ffff);
  emit(enc_r(7'h00, 8, 2, 3'b101, 11));
  emit_sw(11, 32'h51c, 32'h1fff_ffff);
  emit(enc_r(7'h00, 1, 2, 3'b010, 12));
  emit_sw(12, 32'h520, 32'd1);
  emit(enc_r(7'h00, 1, 2, 3'b011, 13));
  emit_sw(13, 32'h524, 32'd0);
  emit(enc_r(7'h00, 2, 1, 3'b100, 14));
  emit_sw(14, 32'h528, 32'hffff_ff9d);
  emit(enc_r(7'h00, 8, 1, 3'b110, 15));
  emit_sw(15, 32'h52c, 32'h67);
  emit(enc_r(7'h00, 2, 1, 3'b111, 16));
  emit_sw(16, 32'h530, 32'h60);
  emit(enc_u(32'habcde, 17, OPC_LUI));
  emit_sw(17, 32'h534, 32'habcd_e000);
  link = cur_addr() + 32'h1000;
  emit(enc_u(32'h1, 18, OPC_AUIPC));
  emit_sw(18, 32'h538, link);
  // loads, one from x0 and one from a nonzero base
  emit(enc_i(DATA0, 0, 3'b010, 19, OPC_LOAD));
  emit_sw(19, 32'h53c, rand0);
  emit(enc_i(DATA1 - 8, 0, 3'b000, 20, OPC_IMM));
  emit(enc_i(8, 20, 3'b010, 21, OPC_LOAD));
  emit_sw(21, 32'h540, rand1);
  // branches, taken ones jump over a poison store
  emit(enc_u(POISON >> 12, 22, OPC_LUI));
  emit_to(enc_b(8, 1, 1, 3'b000), cur_addr() + 8);
  emit_poison();
  emit(enc_b(8, 1, 1, 3'b001));
  emit_to(enc_b(8, 1, 2, 3'b100), cur_addr() + 8);
  emit_poison();
  emit_to(enc_b(8, 2, 1, 3'b101), cur_addr() + 8);
  emit_poison();
  emit(enc_b(8, 1, 2, 3'b110));
  emit_to(enc_b(8, 1, 2, 3'b111), cur_addr() + 8);
  emit_poison();
  emit(enc_b(8, 1, 2, 3'b101));
  // jal, link is its own pc + 4
  link = cur_addr() + 4;
  emit_to(enc_j(8, 23), cur_addr() + 8);
  emit_poison();
  emit_sw(23, 32'h544, link);
  // jalr to an odd address, bit 0 dropped
  emit(enc_i(cur_addr() + 13, 0, 3'b000, 24, OPC_IMM));
  link = cur_addr() + 4;
  emit_to(enc_i(0, 24, 3'b000, 25, OPC_JALR), cur_addr() + 8);
  emit_poison();
  emit_sw(25, 32'h548, link);
  // x0 stays zero
  emit(enc_i(55, 1, 3'b000, 0, OPC_IMM));
  emit_sw(0, 32'h54c, 32'd0);
  // ecall parks the pc
  emit_to(ECALL_INSN, cur_addr());
endtask

`endif

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core
  import rv_core_pkg::*;
();

  localparam int          MEM_WORDS  = 512;
  localparam int          ADDR_MSB   = $clog2(MEM_WORDS) + 1;
  localparam int          MAX_STORES = 32;
  localparam int          TIMEOUT    = 1000;
  localparam int unsigned SEED       = 32'h9f5f;
  localparam word_t       RESET_PC   = '0;
  localparam word_t       ECALL_INSN = 32'h0000_0073;

  logic     clk;
  logic     rst;
  word_t    insn;
  word_t    pc;
  word_t    dmem_addr;
  word_t    dmem_wdata;
  byte_en_t dmem_we;
  word_t    dmem_rdata;
  logic     halt;

  word_t mem [MEM_WORDS];
  word_t next_pc_tbl [MEM_WORDS];
  word_t st_addr [MAX_STORES];
  word_t st_data [MAX_STORES];
  int    prog_len;
  int    num_stores;
  int    store_idx;
  word_t prev_pc;
  logic  prev_valid;
  word_t exp_pc;
  word_t exp_addr;
  word_t exp_data;
  int    cycles;

  `include "rv_program.svh"

  rv_core #(
    .RESET_PC(RESET_PC)
  ) i_dut (
    .clk         (clk),
    .rst         (rst),
    .i_insn      (insn),
    .o_pc        (pc),
    .o_dmem_addr (dmem_addr),
    .o_dmem_wdata(dmem_wdata),
    .o_dmem_we   (dmem_we),
    .i_dmem_rdata(dmem_rdata),
    .o_halt      (halt)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #10 clk = ~clk;
    end
  end

  // combinational memory, read-first
  assign insn       = mem[pc[ADDR_MSB:2]];
  assign dmem_rdata = mem[dmem_addr[ADDR_MSB:2]];

  always @(posedge clk)
  begin
    if (!rst)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (dmem_we[b])
        begin
          mem[dmem_addr[ADDR_MSB:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  // previous pc and position in the expected store list
  always @(posedge clk)
  begin
    prev_pc    <= pc;
    prev_valid <= !rst;
    if (rst)
    begin
      store_idx <= 0;
    end
    else if (dmem_we != '0)
    begin
      store_idx <= store_idx + 1;
    end
  end

  assign exp_pc   = next_pc_tbl[prev_pc[ADDR_MSB:2]];
  assign exp_addr = st_addr[store_idx];
  assign exp_data = st_data[store_idx];

  task automatic stop_on_error();
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  a_reset_pc: assert property (@(posedge clk) disable iff (rst)
    !prev_valid |-> pc == RESET_PC)
    else
    begin
      $display("ERROR %0t o_pc expected %h actual %h", $time, RESET_PC, $sampled(pc));
      stop_on_error();
    end

  a_reset_halt: assert property (@(posedge clk) disable iff (rst) !prev_valid |-> !halt)
    else
    begin
      $display("ERROR %0t o_halt expected 0 actual %b", $time, $sampled(halt));
      stop_on_error();
    end

  a_pc_next: assert property (@(posedge clk) disable iff (rst) prev_valid |-> pc == exp_pc)
    else
    begin
      $display("ERROR %0t o_pc expected %h actual %h", $time, $sampled(exp_pc), $sampled(pc));
      stop_on_error();
    end

  a_store_we: assert property (@(posedge clk) disable iff (rst)
    dmem_we != '0 |-> dmem_we == 4'hf)
    else
    begin
      $display("ERROR %0t o_dmem_we expected f actual %h", $time, $sampled(dmem_we));
      stop_on_error();
    end

  a_no_poison: assert property (@(posedge clk) disable iff (rst)
    dmem_we != '0 |-> dmem_wdata != POISON)
    else
    begin
      $display("a store that a taken branch or jump should skip was executed");
      stop_on_error();
    end

  a_store_count: assert property (@(posedge clk) disable iff (rst)
    dmem_we != '0 |-> store_idx < num_stores)
    else
    begin
      $display("the core made more stores than the program holds");
      stop_on_error();
    end

  a_store_addr: assert property (@(posedge clk) disable iff (rst)
    dmem_we != '0 |-> dmem_addr == exp_addr)
    else
    begin
      $display("ERROR %0t o_dmem_addr expected %h actual %h", $time, $sampled(exp_addr),
               $sampled(dmem_addr));
      stop_on_error();
    end

  a_store_data: assert property (@(posedge clk) disable iff (rst)
    dmem_we != '0 |-> dmem_wdata == exp_data)
    else
    begin
      $display("ERROR %0t o_dmem_wdata expected %h actual %h", $time, $sampled(exp_data),
               $sampled(dmem_wdata));
      stop_on_error();
    end

  a_halt_on_ecall: assert property (@(posedge clk) disable iff (rst)
    (insn == ECALL_INSN && !halt) |=> halt)
    else
    begin
      $display("ERROR %0t o_halt expected 1 actual %b", $time, $sampled(halt));
      stop_on_error();
    end

  a_no_early_halt: assert property (@(posedge clk) disable iff (rst)
    (insn != ECALL_INSN && !halt) |=> !halt)
    else
    begin
      $display("the core halted without an ecall");
      stop_on_error();
    end

  a_halt_pc_hold: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else
    begin
      $display("the pc moved after halt");
      stop_on_error();
    end

  a_halt_no_store: assert property (@(posedge clk) disable iff (rst) halt |-> dmem_we == '0)
    else
    begin
      $display("ERROR %0t o_dmem_we expected 0 actual %h", $time, $sampled(dmem_we));
      stop_on_error();
    end

  a_all_stores_seen: assert property (@(posedge clk) disable iff (rst)
    halt |-> store_idx == num_stores)
    else
    begin
      $display("ERROR %0t store count expected %0d actual %0d", $time, num_stores,
               $sampled(store_idx));
      stop_on_error();
    end

  initial
  begin
    word_t rand0;
    word_t rand1;
    rst = 1'b1;
    void'($urandom(SEED));
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      // fill word carries its own byte address
      mem[i] = 32'hc0de_0000 ^ (word_t'(i) << 2);
    end
    rand0 = $urandom;
    rand1 = $urandom;
    load_program(rand0, rand1);
    repeat (8) @(posedge clk);
    #2 rst = 1'b0;
    cycles = 0;
    while (!halt && cycles < TIMEOUT)
    begin
      @(posedge clk);
      #2 cycles++;
    end
    if (!halt)
    begin
      $display("the core did not halt within %0d cycles", TIMEOUT);
      $display("TESTS FAILED");
      $fatal(1, "timeout waiting for halt");
    end
    else
    begin
      // halted state keeps being checked for a while
      repeat (16) @(posedge clk);
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic     clk,
  input  logic     rst,
  input  word_t    i_insn,
  output word_t    o_pc,
  output word_t    o_dmem_addr,
  output word_t    o_dmem_wdata,
  output byte_en_t o_dmem_we,
  input  word_t    i_dmem_rdata,
  output logic     o_halt
);

  // decoded instruction
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  alu_op_t  alu_op;
  logic     use_imm;
  br_cond_t br_cond;
  wb_sel_t  wb_sel;
  logic     is_jal;
  logic     is_jalr;
  logic     is_load;
  logic     is_store;
  logic     reg_write;
  logic     ecall;

  // datapath
  word_t    pc_plus4;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    wb_data;
  logic     rf_we;
  logic     redirect;
  word_t    target;

  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) i_fetch (
    .clk        (clk),
    .rst        (rst),
    .i_redirect (redirect),
    .i_target   (target),
    .i_ecall    (ecall),
    .i_reg_write(reg_write),
    .o_pc       (o_pc),
    .o_pc_plus4 (pc_plus4),
    .o_rf_we    (rf_we),
    .o_halt     (o_halt)
  );

  rv_decoder i_decoder (
    .i_insn     (i_insn),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (rd),
    .o_imm      (imm),
    .o_alu_op   (alu_op),
    .o_use_imm  (use_imm),
    .o_br_cond  (br_cond),
    .o_wb_sel   (wb_sel),
    .o_is_jal   (is_jal),
    .o_is_jalr  (is_jalr),
    .o_is_load  (is_load),
    .o_is_store (is_store),
    .o_reg_write(reg_write),
    .o_ecall    (ecall)
  );

  rv_regfile i_regfile (
    .clk       (clk),
    .rst       (rst),
    .i_rs1     (rs1),
    .i_rs2     (rs2),
    .i_rd      (rd),
    .i_we      (rf_we),
    .i_wdata   (wb_data),
    .o_rs1_data(rs1_data),
    .o_rs2_data(rs2_data)
  );

  rv_execute i_execute (
    .i_pc        (o_pc),
    .i_pc_plus4  (pc_plus4),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_imm       (imm),
    .i_alu_op    (alu_op),
    .i_use_imm   (use_imm),
    .i_br_cond   (br_cond),
    .i_wb_sel    (wb_sel),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .i_is_load   (is_load),
    .i_is_store  (is_store),
    .i_dmem_rdata(i_dmem_rdata),
    .o_wb_data   (wb_data),
    .o_redirect  (redirect),
    .o_target    (target),
    .o_dmem_addr (o_dmem_addr),
    .o_dmem_wdata(o_dmem_wdata),
    .o_dmem_we   (o_dmem_we)
  );

endmodule

// ==== hdl/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  i_redirect,
  input  word_t i_target,
  input  logic  i_ecall,
  input  logic  i_reg_write,
  output word_t o_pc,
  output word_t o_pc_plus4,
  output logic  o_rf_we,
  output logic  o_halt
);

  word_t pc_q;
  logic  halt_q;

  assign o_pc_plus4 = pc_q + word_t'(4);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q   <= RESET_PC;
      halt_q <= 1'b0;
    end
    else
    begin
      // sticky until the next reset
      if (i_ecall)
      begin
        halt_q <= 1'b1;
      end
      // pc parks on the ecall so nothing after it is ever decoded
      if (!halt_q && !i_ecall)
      begin
        pc_q <= i_redirect ? i_target : o_pc_plus4;
      end
    end
  end

  assign o_pc    = pc_q;
  assign o_halt  = halt_q;
  assign o_rf_we = i_reg_write && !halt_q;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00)
    else $error("fetch: pc %h not word aligned", pc_q);

endmodule

// ==== hdl/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  word_t    i_pc,
  input  word_t    i_pc_plus4,
  input  word_t    i_rs1_data,
  input  word_t    i_rs2_data,
  input  word_t    i_imm,
  input  alu_op_t  i_alu_op,
  input  logic     i_use_imm,
  input  br_cond_t i_br_cond,
  input  wb_sel_t  i_wb_sel,
  input  logic     i_is_jal,
  input  logic     i_is_jalr,
  input  logic     i_is_load,
  input  logic     i_is_store,
  input  word_t    i_dmem_rdata,
  output word_t    o_wb_data,
  output logic     o_redirect,
  output word_t    o_target,
  output word_t    o_dmem_addr,
  output word_t    o_dmem_wdata,
  output byte_en_t o_dmem_we
);

  word_t      op_b;
  logic [4:0] shamt;
  word_t      alu_result;
  word_t      pc_rel;
  logic       taken;

  assign op_b  = i_use_imm ? i_imm : i_rs2_data;
  assign shamt = op_b[4:0];

  always_comb
  begin
    case (i_alu_op)
      ALU_ADD:  alu_result = i_rs1_data + op_b;
      ALU_SUB:  alu_result = i_rs1_data - op_b;
      ALU_SLL:  alu_result = i_rs1_data << shamt;
      ALU_SLT:  alu_result = word_t'($signed(i_rs1_data) < $signed(op_b));
      ALU_SLTU: alu_result = word_t'(i_rs1_data < op_b);
      ALU_XOR:  alu_result = i_rs1_data ^ op_b;
      ALU_SRL:  alu_result = i_rs1_data >> shamt;
      // arithmetic shift keeps the sign bit
      ALU_SRA:  alu_result = word_t'($signed(i_rs1_data) >>> shamt);
      ALU_OR:   alu_result = i_rs1_data | op_b;
      ALU_AND:  alu_result = i_rs1_data & op_b;
      default:  alu_result = '0;
    endcase
  end

  // branch compare always works on both registers
  always_comb
  begin
    case (i_br_cond)
      BR_EQ:   taken = (i_rs1_data == i_rs2_data);
      BR_NE:   taken = (i_rs1_data != i_rs2_data);
      BR_LT:   taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
      BR_GE:   taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_LTU:  taken = (i_rs1_data < i_rs2_data);
      BR_GEU:  taken = (i_rs1_data >= i_rs2_data);
      default: taken = 1'b0;
    endcase
  end

  // shared by branches, jal and auipc
  assign pc_rel = i_pc + i_imm;

  assign o_redirect = taken || i_is_jal || i_is_jalr;
  // jalr drops bit 0 of rs1 + imm
  assign o_target   = i_is_jalr ? {alu_result[31:1], 1'b0} : pc_rel;

  always_comb
  begin
    case (i_wb_sel)
      WB_ALU:  o_wb_data = alu_result;
      // lui takes the raw immediate, auipc the pc relative sum
      WB_IMM:  o_wb_data = i_use_imm ? pc_rel : i_imm;
      WB_PC4:  o_wb_data = i_pc_plus4;
      default: o_wb_data = i_dmem_rdata;
    endcase
  end

  // word accesses only, address from the ALU adder
  assign o_dmem_addr  = alu_result;
  assign o_dmem_wdata = i_rs2_data;
  assign o_dmem_we    = i_is_store ? '1 : '0;

  a_mem_aligned: assert final (!(i_is_load || i_is_store) || (alu_result[1:0] == 2'b00))
    else $error("execute: misaligned word access at %h", alu_result);

endmodule

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  input  reg_idx_t i_rd,
  input  logic     i_we,
  input  word_t    i_wdata,
  output word_t    o_rs1_data,
  output word_t    o_rs2_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (i_we && (i_rd != '0))
    begin
      regs[i_rd] <= i_wdata;
    end
  end

  // x0 is cleared on reset and never written
  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    ((i_rs1 == '0) -> (o_rs1_data == '0)) && ((i_rs2 == '0) -> (o_rs2_data == '0)))
    else $error("regfile: x0 read returned nonzero");

endmodule

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  word_t    i_insn,
  output reg_idx_t o_rs1,
  output reg_idx_t o_rs2,
  output reg_idx_t o_rd,
  output word_t    o_imm,
  output alu_op_t  o_alu_op,
  output logic     o_use_imm,
  output br_cond_t o_br_cond,
  output wb_sel_t  o_wb_sel,
  output logic     o_is_jal,
  output logic     o_is_jalr,
  output logic     o_is_load,
  output logic     o_is_store,
  output logic     o_reg_write,
  output logic     o_ecall
);

  logic [OPCODE_W-1:0] opcode_raw;
  opcode_t             opcode;
  funct3_t             funct3;
  funct7_t             funct7;
  logic                alt;
  word_t               imm_i;
  word_t               imm_s;
  word_t               imm_b;
  word_t               imm_j;
  word_t               imm_u;
  word_t               imm_shamt;

  // funct3 to ALU operation, alt picks sub or sra
  function automatic alu_op_t alu_from_funct3(input funct3_t f3, input logic f7_alt);
    alu_op_t op;
    case (f3)
      F3_ADD:  op = f7_alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = f7_alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // instruction fields
  assign opcode_raw = i_insn[6:0];
  assign opcode     = opcode_t'(opcode_raw);
  assign funct3     = i_insn[14:12];
  assign funct7     = i_insn[31:25];
  assign alt        = (funct7 == FUNCT7_ALT);
  assign o_rd       = i_insn[11:7];
  assign o_rs1      = i_insn[19:15];
  assign o_rs2      = i_insn[24:20];

  // sign-extended immediates per format
  assign imm_i     = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s     = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b     = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_j     = {{12{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
  assign imm_u     = {i_insn[31:12], 12'b0};
  assign imm_shamt = word_t'(i_insn[24:20]);

  always_comb
  begin
    o_imm       = imm_i;
    o_alu_op    = ALU_ADD;
    o_use_imm   = 1'b0;
    o_br_cond   = BR_NONE;
    o_wb_sel    = WB_ALU;
    o_is_jal    = 1'b0;
    o_is_jalr   = 1'b0;
    o_is_load   = 1'b0;
    o_is_store  = 1'b0;
    o_reg_write = 1'b0;
    o_ecall     = 1'b0;
    case (opcode)
      OP_LUI:
      begin
        // raw immediate straight to rd
        o_imm       = imm_u;
        o_wb_sel    = WB_IMM;
        o_reg_write = 1'b1;
      end
      OP_AUIPC:
      begin
        // immediate writeback with use_imm set means pc relative
        o_imm       = imm_u;
        o_use_imm   = 1'b1;
        o_wb_sel    = WB_IMM;
        o_reg_write = 1'b1;
      end
      OP_JAL:
      begin
        o_imm       = imm_j;
        o_is_jal    = 1'b1;
        o_wb_sel    = WB_PC4;
        o_reg_write = 1'b1;
      end
      OP_JALR:
      begin
        // target comes out of the ALU adder
        o_use_imm   = 1'b1;
        o_is_jalr   = 1'b1;
        o_wb_sel    = WB_PC4;
        o_reg_write = 1'b1;
      end
      OP_BRANCH:
      begin
        o_imm = imm_b;
        case (funct3)
          F3_BEQ:  o_br_cond = BR_EQ;
          F3_BNE:  o_br_cond = BR_NE;
          F3_BLT:  o_br_cond = BR_LT;
          F3_BGE:  o_br_cond = BR_GE;
          F3_BLTU: o_br_cond = BR_LTU;
          F3_BGEU: o_br_cond = BR_GEU;
          default: o_br_cond = BR_NONE;
        endcase
      end
      OP_LOAD:
      begin
        o_use_imm   = 1'b1;
        o_is_load   = 1'b1;
        o_wb_sel    = WB_LOAD;
        o_reg_write = 1'b1;
      end
      OP_STORE:
      begin
        o_imm      = imm_s;
        o_use_imm  = 1'b1;
        o_is_store = 1'b1;
      end
      OP_IMM:
      begin
        // bit 30 of addi/xori immediates is data, only shifts see alt
        o_use_imm   = 1'b1;
        o_alu_op    = alu_from_funct3(funct3, alt && (funct3 == F3_SR));
        o_reg_write = 1'b1;
        if (funct3 == F3_SLL || funct3 == F3_SR)
        begin
          o_imm = imm_shamt;
        end
      end
      OP_OP:
      begin
        o_alu_op    = alu_from_funct3(funct3, alt);
        o_reg_write = 1'b1;
      end
      OP_SYSTEM:
      begin
        o_ecall = (i_insn[31:7] == '0);
      end
      default:
      begin
      end
    endcase
  end

  // X is only seen before the instruction image is loaded
  a_opcode_known: assert final ($isunknown(opcode_raw) || opcode_raw inside
    {OP_LOAD, OP_STORE, OP_BRANCH, OP_JALR, OP_JAL, OP_IMM, OP_OP, OP_SYSTEM,
     OP_AUIPC, OP_LUI})
    else $error("decoder: unsupported opcode %b", opcode_raw);

endmodule

// ==== hdl/rv_core_pkg.sv ====
package rv_core_pkg;

  // RV32 machine word
  localparam int XLEN = 32;

  // architectural integer registers
  localparam int NUM_REGS = 32;

  // data or address word
  typedef logic [XLEN-1:0] word_t;

  // register file index
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  // one enable per byte lane of a word
  typedef logic [XLEN/8-1:0] byte_en_t;

endpackage

// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // instruction field widths
  localparam int OPCODE_W = 7;
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;

  typedef logic [FUNCT3_W-1:0] funct3_t;
  typedef logic [FUNCT7_W-1:0] funct7_t;

  // major opcodes handled by the core
  typedef enum logic [OPCODE_W-1:0] {
    OP_LOAD   = 7'b00_000_11,
    OP_STORE  = 7'b01_000_11,
    OP_BRANCH = 7'b11_000_11,
    OP_JALR   = 7'b11_001_11,
    OP_JAL    = 7'b11_011_11,
    OP_IMM    = 7'b00_100_11,
    OP_OP     = 7'b01_100_11,
    OP_SYSTEM = 7'b11_100_11,
    OP_AUIPC  = 7'b00_101_11,
    OP_LUI    = 7'b01_101_11
  } opcode_t;

  // funct3 of the integer ALU group
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // funct3 of the branch group
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // selects sub over add and sra over srl
  localparam funct7_t FUNCT7_ALT = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_cond_t;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_IMM,
    WB_PC4,
    WB_LOAD
  } wb_sel_t;

endpackage
